/* uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // ======================================================================
    // timing and message constants
    // ======================================================================
    localparam int OVERSAMPLE    = 16;    // ticks per bit.
    localparam int TICK_DIV      = 4;     // clocks per tick.
    localparam int MSG_LEN       = 15;    // greeting bytes.
    localparam int BEACON_PERIOD = 3000;  // idle clocks between greetings.

    localparam int TICK_W   = $clog2(TICK_DIV);
    localparam int OS_W     = $clog2(OVERSAMPLE);
    localparam int MSG_W    = $clog2(MSG_LEN);
    localparam int BEACON_W = $clog2(BEACON_PERIOD + 1);

    localparam logic [TICK_W-1:0]   TICK_LAST   = TICK_W'(TICK_DIV - 1);
    localparam logic [OS_W-1:0]     OS_LAST     = OS_W'(OVERSAMPLE - 1);
    localparam logic [OS_W-1:0]     OS_MID      = OS_W'(OVERSAMPLE / 2 - 1);
    localparam logic [MSG_W-1:0]    MSG_LAST    = MSG_W'(MSG_LEN - 1);
    localparam logic [BEACON_W-1:0] BEACON_LAST = BEACON_W'(BEACON_PERIOD);

    // ======================================================================
    // modes and state encodings
    // ======================================================================
    typedef enum logic {
        MODE_ECHO,
        MODE_BEACON
    } mode_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ECHO,
        CTRL_WAIT,
        CTRL_SEND
    } ctrl_state_t;

endpackage

`default_nettype wire

/* byte_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;

    logic [7:0] data;
    logic       valid;
    logic       ready;
    logic       err;   // stop bit was low.

    modport src (
        output data,
        output valid,
        output err,
        input  ready
    );

    modport dst (
        input  data,
        input  valid,
        input  err,
        output ready
    );

endinterface

`default_nettype wire

/* baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module baud_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [uart_pkg::TICK_W-1:0] div_cnt;

    // free running divider, one tick per TICK_DIV clocks.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == uart_pkg::TICK_LAST) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       rxd,
    byte_stream_if.src out
);

    uart_pkg::rx_state_t       state;
    logic [2:0]                rxd_sync;
    logic                      rxd_s;
    logic                      rxd_fell;
    logic [uart_pkg::OS_W-1:0] os_cnt;
    logic [2:0]                bit_idx;
    logic                      bit_end;
    logic [7:0]                shreg;
    logic                      stop_bit;
    logic                      done;

    assign rxd_s    = rxd_sync[1];
    assign rxd_fell = rxd_sync[2] & ~rxd_sync[1];
    assign bit_end  = tick && (os_cnt == uart_pkg::OS_LAST);

    // two flop synchronizer plus one delay for edge detect.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_sync <= 3'b111;
        end else begin
            rxd_sync <= {rxd_sync[1:0], rxd};
        end
    end

    // ======================================================================
    // frame state machine
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= uart_pkg::RX_IDLE;
            os_cnt  <= '0;
            bit_idx <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (rxd_fell) begin
                        state  <= uart_pkg::RX_START;
                        os_cnt <= '0;
                    end
                end
                uart_pkg::RX_START: begin
                    if (tick) begin
                        if (os_cnt == uart_pkg::OS_MID) begin
                            // line back high means a glitch, not a start bit.
                            state   <= rxd_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                            os_cnt  <= '0;
                            bit_idx <= '0;
                        end else begin
                            os_cnt <= os_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        os_cnt  <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::RX_STOP;
                        end
                    end else if (tick) begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        os_cnt <= '0;
                        done   <= 1'b1;
                        state  <= uart_pkg::RX_IDLE;
                    end else if (tick) begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // mid-bit samples, lsb arrives first.
    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_DATA && bit_end) begin
            shreg <= {rxd_s, shreg[7:1]};
        end
        if (state == uart_pkg::RX_STOP && bit_end) begin
            stop_bit <= rxd_s;
        end
    end

    // ======================================================================
    // output holding register
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (done) begin
            out.valid <= 1'b1;  // a new byte overwrites an unread one.
        end else if (out.ready) begin
            out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            out.data <= shreg;
            out.err  <= ~stop_bit;
        end
    end

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic [7:0] data,
    input  logic       valid,
    output logic       ready,
    output logic       txd,
    output logic       busy
);

    uart_pkg::tx_state_t       state;
    logic [uart_pkg::OS_W-1:0] os_cnt;
    logic [2:0]                bit_idx;
    logic [7:0]                shreg;
    logic                      accept;
    logic                      bit_end;

    assign ready   = (state == uart_pkg::TX_IDLE);
    assign busy    = ~ready;
    assign accept  = valid & ready;
    assign bit_end = tick && (os_cnt == uart_pkg::OS_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= uart_pkg::TX_IDLE;
            os_cnt  <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (accept) begin
                        state  <= uart_pkg::TX_START;
                        os_cnt <= '0;
                    end
                end
                uart_pkg::TX_START: begin
                    if (tick && txd) begin
                        txd <= 1'b0;  // start bit opens on a tick.
                    end else if (bit_end) begin
                        state   <= uart_pkg::TX_DATA;
                        os_cnt  <= '0;
                        bit_idx <= '0;
                        txd     <= shreg[0];
                    end else if (tick) begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        os_cnt  <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            txd <= shreg[0];
                        end
                    end else if (tick) begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        state  <= uart_pkg::TX_IDLE;
                        os_cnt <= '0;
                    end else if (tick) begin
                        os_cnt <= os_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // next data bit always sits in shreg[0].
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= data;
        end else if (bit_end && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

/* io_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module io_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  uart_pkg::mode_t   mode,
    byte_stream_if.dst        in,
    output logic [7:0]        tx_data,
    output logic              tx_valid,
    input  logic              tx_ready
);

    uart_pkg::ctrl_state_t           state;
    logic [7:0]                      echo_byte;
    logic [uart_pkg::MSG_W-1:0]      msg_idx;
    logic [uart_pkg::BEACON_W-1:0]   beacon_cnt;
    logic                            rx_take;

    // greeting text, ends with cr lf.
    function automatic logic [7:0] msg_byte(input logic [uart_pkg::MSG_W-1:0] idx);
        case (idx)
            4'd0:    msg_byte = "H";
            4'd1:    msg_byte = "e";
            4'd2:    msg_byte = "l";
            4'd3:    msg_byte = "l";
            4'd4:    msg_byte = "o";
            4'd5:    msg_byte = ",";
            4'd6:    msg_byte = " ";
            4'd7:    msg_byte = "w";
            4'd8:    msg_byte = "o";
            4'd9:    msg_byte = "r";
            4'd10:   msg_byte = "l";
            4'd11:   msg_byte = "d";
            4'd12:   msg_byte = "!";
            4'd13:   msg_byte = 8'h0D;
            4'd14:   msg_byte = 8'h0A;
            default: msg_byte = 8'h00;
        endcase
    endfunction

    // ======================================================================
    // handshakes
    // ======================================================================
    // in beacon mode idle still drains the receiver, so no stale echo later.
    assign in.ready = (state == uart_pkg::CTRL_IDLE);
    assign rx_take  = in.valid & in.ready;

    assign tx_valid = (state == uart_pkg::CTRL_ECHO) || (state == uart_pkg::CTRL_SEND);
    assign tx_data  = (state == uart_pkg::CTRL_SEND) ? msg_byte(msg_idx) : echo_byte;

    always_ff @(posedge clk) begin
        if (rx_take) begin
            echo_byte <= in.data;
        end
    end

    // ======================================================================
    // control state machine
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= uart_pkg::CTRL_IDLE;
            msg_idx    <= '0;
            beacon_cnt <= '0;
        end else begin
            case (state)
                uart_pkg::CTRL_IDLE: begin
                    if (mode == uart_pkg::MODE_ECHO) begin
                        if (rx_take && !in.err) begin
                            state <= uart_pkg::CTRL_ECHO;  // bad frames are dropped.
                        end
                    end else if (beacon_cnt == uart_pkg::BEACON_LAST) begin
                        state   <= uart_pkg::CTRL_SEND;
                        msg_idx <= '0;
                    end else begin
                        beacon_cnt <= beacon_cnt + 1'b1;
                    end
                end
                uart_pkg::CTRL_ECHO: begin
                    if (tx_ready) begin
                        state <= uart_pkg::CTRL_IDLE;
                    end
                end
                uart_pkg::CTRL_SEND: begin
                    if (tx_ready) begin
                        state <= uart_pkg::CTRL_WAIT;
                    end
                end
                default: begin
                    // transmitter idle again, byte is out.
                    if (tx_ready) begin
                        if (msg_idx == uart_pkg::MSG_LAST) begin
                            state      <= uart_pkg::CTRL_IDLE;
                            beacon_cnt <= '0;
                        end else begin
                            state   <= uart_pkg::CTRL_SEND;
                            msg_idx <= msg_idx + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  logic clk,
    input  logic rst,
    input  logic rxd,
    input  logic mode,
    output logic txd,
    output logic tx_busy
);

    uart_pkg::mode_t ctrl_mode;
    logic            tick;
    logic [7:0]      tx_data;
    logic            tx_valid;
    logic            tx_ready;

    byte_stream_if rx_link ();

    assign ctrl_mode = mode ? uart_pkg::MODE_BEACON : uart_pkg::MODE_ECHO;  // 1 is beacon.

    baud_gen u_baud (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_rx u_rx (
        .clk  (clk),
        .rst  (rst),
        .tick (tick),
        .rxd  (rxd),
        .out  (rx_link.src)
    );

    io_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .mode     (ctrl_mode),
        .in       (rx_link.dst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    uart_tx u_tx (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .data  (tx_data),
        .valid (tx_valid),
        .ready (tx_ready),
        .txd   (txd),
        .busy  (tx_busy)
    );

endmodule

`default_nettype wire

/* tb_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;

    localparam int BIT_CYCLES   = uart_pkg::OVERSAMPLE * uart_pkg::TICK_DIV;
    localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
    localparam int START_LIMIT  = uart_pkg::BEACON_PERIOD + 2 * FRAME_CYCLES;
    localparam int N_ECHO       = 8;  // entries for the echo phase.
    localparam int N_ENTRIES    = 9;
    localparam logic [8*15-1:0] GREETING = {"Hello, world!", 8'h0D, 8'h0A};

    typedef struct packed {
        logic [7:0] data;
        logic       stop_good;
        logic       echo;
    } frame_entry_t;

    logic         clk;
    logic         rst;
    logic         rxd;
    logic         mode;
    logic         txd;
    logic         tx_busy;
    logic [31:0]  lfsr_state;
    frame_entry_t frames [N_ENTRIES];

    uart_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .rxd     (rxd),
        .mode    (mode),
        .txd     (txd),
        .tx_busy (tx_busy)
    );

    always #5 clk = ~clk;

    // ======================================================================
    // helpers
    // ======================================================================
    task automatic fail_run();
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // one clock, then settle 1 ns past the edge.
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1.
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        logic [7:0] acc;
        acc = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            acc = {acc[6:0], lfsr_state[0]};
        end
        b = acc;
    endtask

    task automatic fill_table();
        logic [7:0] r;
        frames[0] = '{8'h00, 1'b1, 1'b1};
        frames[1] = '{8'hFF, 1'b1, 1'b1};
        frames[2] = '{8'h55, 1'b1, 1'b1};
        frames[6] = '{8'h3C, 1'b0, 1'b0};  // framing error.
        for (int i = 3; i < N_ENTRIES; i++) begin
            if (i != 6) begin
                draw_byte(r);
                frames[i] = '{r, (i != 4), (i != 4)};
            end
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] got);
        assert (got === exp) else begin
            $display("[ERROR] %s: expected %02h, got %02h", what, exp, got);
            fail_run();
        end
    endtask

    // txd idle and transmitter not busy for n cycles.
    task automatic check_quiet(input int n);
        for (int i = 0; i < n; i++) begin
            wait_cycles(1);
            assert (txd === 1'b1) else begin
                $display("[ERROR] txd: expected 1, got %h", txd);
                fail_run();
            end
            assert (tx_busy === 1'b0) else begin
                $display("[ERROR] tx_busy: expected 0, got %h", tx_busy);
                fail_run();
            end
        end
    endtask

    // previous frame may still be in its stop bit.
    task automatic wait_tx_idle();
        int waited;
        waited = 0;
        while (tx_busy !== 1'b0 && waited < FRAME_CYCLES) begin
            wait_cycles(1);
            waited++;
        end
        assert (tx_busy === 1'b0) else begin
            $display("transmitter still busy after %0d cycles", FRAME_CYCLES);
            fail_run();
        end
    endtask

    // ======================================================================
    // serial driver and monitor
    // ======================================================================
    task automatic drive_frame(input logic [7:0] data, input logic stop_good);
        rxd = 1'b0;
        wait_cycles(BIT_CYCLES);
        for (int i = 0; i < 8; i++) begin
            rxd = data[i];
            wait_cycles(BIT_CYCLES);
        end
        rxd = stop_good;
        wait_cycles(BIT_CYCLES);
        rxd = 1'b1;
    endtask

    task automatic capture_frame(output logic [7:0] data);
        int         waited;
        logic [7:0] bits;
        waited = 0;
        bits   = 8'h00;
        while (txd !== 1'b0 && waited < START_LIMIT) begin
            wait_cycles(1);
            waited++;
        end
        assert (txd === 1'b0) else begin
            $display("no start bit appeared on txd within %0d cycles", START_LIMIT);
            fail_run();
        end
        wait_cycles(BIT_CYCLES / 2);  // centre of start bit.
        assert (txd === 1'b0) else begin
            $display("[ERROR] txd start bit: expected 0, got %h", txd);
            fail_run();
        end
        assert (tx_busy === 1'b1) else begin
            $display("[ERROR] tx_busy: expected 1, got %h", tx_busy);
            fail_run();
        end
        for (int i = 0; i < 8; i++) begin
            wait_cycles(BIT_CYCLES);
            bits[i] = txd;
        end
        wait_cycles(BIT_CYCLES);
        assert (txd === 1'b1) else begin
            $display("[ERROR] txd stop bit: expected 1, got %h", txd);
            fail_run();
        end
        data = bits;
    endtask

    task automatic run_entry(input int idx);
        frame_entry_t e;
        logic [7:0]   got;
        e = frames[idx];
        if (e.echo) begin
            fork
                drive_frame(e.data, e.stop_good);
                capture_frame(got);
            join
            check_byte("txd echo byte", e.data, got);
        end else begin
            wait_tx_idle();
            fork
                drive_frame(e.data, e.stop_good);
                check_quiet(2 * FRAME_CYCLES);
            join
        end
    endtask

    task automatic receive_greeting(input int first, input int last);
        logic [7:0] got;
        for (int i = first; i < last; i++) begin
            capture_frame(got);
            check_byte("txd greeting byte", GREETING[8*(uart_pkg::MSG_LEN-1-i) +: 8], got);
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        rxd        = 1'b1;
        mode       = 1'b0;  // echo.
        lfsr_state = 32'he99d;
        fill_table();
        wait_cycles(3);
        rst = 1'b0;

        check_quiet(20);

        for (int i = 0; i < N_ECHO; i++) begin
            run_entry(i);
        end

        mode = 1'b1;  // beacon.
        receive_greeting(0, uart_pkg::MSG_LEN);
        receive_greeting(0, uart_pkg::MSG_LEN);

        // back to echo in the middle of a greeting.
        receive_greeting(0, 1);
        mode = 1'b0;
        receive_greeting(1, uart_pkg::MSG_LEN);
        run_entry(N_ECHO);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
uart_pkg.sv
byte_stream_if.sv
baud_gen.sv
uart_rx.sv
uart_tx.sv
io_ctrl.sv
uart_top.sv
tb_uart_top.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_uart_top -f sources.f || exit 1
./obj_dir/Vtb_uart_top | tee /dev/stderr | grep -x "Simulation PASSED" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
